// File: Bender.yml
package:
  name: music_player

sources:
  # RTL in compile order
  - hdl/music_pkg.sv
  - hdl/note_if.sv
  - hdl/mcu.sv
  - hdl/beat_generator.sv
  - hdl/song_reader.sv
  - hdl/note_player.sv
  - hdl/codec_conditioner.sv
  - hdl/music_player.sv
  # Simulation only
  - target: test
    files:
      - test/tb_music_player.sv

// File: hdl/beat_generator.sv
// Divides the sample strobe down to the beat pulse that paces note durations
`timescale 1ns/1ps

module beat_generator #(
    parameter int BEAT_COUNT = 1000
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic beat
);

    // Counter wide enough for BEAT_COUNT-1, at least one bit
    localparam int CNT_W = (BEAT_COUNT > 1) ? $clog2(BEAT_COUNT) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(BEAT_COUNT - 1);

    logic [CNT_W-1:0] count;

    // Beat coincides with the enable that wraps the counter
    assign beat = en && (count == LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (en) begin
            if (count == LAST) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: hdl/codec_conditioner.sv
// Mixes the three voices, holds the sum and hands it to the codec on each frame
`timescale 1ns/1ps

module codec_conditioner
    import music_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  sample_t sample_one,
    input  sample_t sample_two,
    input  sample_t sample_three,
    input  logic    latch_new_sample_in,
    input  logic    new_frame,
    output logic    generate_next_sample,
    output sample_t valid_sample
);

    sample_t mix;
    sample_t held;

    // Each voice scaled by a quarter so three peaks cannot overflow
    assign mix = (sample_one >>> 2) + (sample_two >>> 2) + (sample_three >>> 2);

    always_ff @(posedge clk) begin
        if (rst) begin
            held                 <= '0;
            valid_sample         <= '0;
            generate_next_sample <= 1'b0;
        end else begin
            // Request the next sample as this frame goes out
            generate_next_sample <= new_frame;
            // Mix of the voices, ready before the next frame
            if (latch_new_sample_in) begin
                held <= mix;
            end
            // Release the sum made for the previous frame
            if (new_frame) begin
                valid_sample <= held;
            end
        end
    end

    // Codec frames are far apart, never back to back
    a_frame_spacing : assert property (@(posedge clk) disable iff (rst)
        new_frame |=> !new_frame);

endmodule

// File: hdl/mcu.sv
// Play, pause and next-song control FSM driving the song reader from the button pulses
`timescale 1ns/1ps

module mcu
    import music_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       play_button,
    input  logic       next_button,
    input  logic       song_done,
    output logic       play,
    output logic       reset_player,
    output logic [1:0] song
);

    mcu_state_e state;
    mcu_state_e state_next;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            paused: begin
                // Song change wins over play
                if (next_button || song_done) begin
                    state_next = load_song;
                end else if (play_button) begin
                    state_next = playing;
                end
            end
            playing: begin
                if (next_button || song_done) begin
                    state_next = load_song;
                end else if (play_button) begin
                    state_next = paused;
                end
            end
            // Single step, always lands paused
            load_song: begin
                state_next = paused;
            end
            default: begin
                state_next = paused;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= paused;
            song  <= '0;
        end else begin
            state <= state_next;
            // Step to the next song, wrapping at the last one
            if (state == load_song) begin
                song <= (song == 2'(NUM_SONGS - 1)) ? '0 : song + 2'd1;
            end
        end
    end

    assign play         = (state == playing);
    // Row counter restart for the song reader
    assign reset_player = (state == load_song);

    // Buttons come from one-pulsers that never fire together
    a_one_button : assert property (@(posedge clk) disable iff (rst)
        !(play_button && next_button));

endmodule

// File: hdl/music_pkg.sv
// Types, constants and the note-to-phase-step table shared by the music player RTL and testbench
package music_pkg;

    // Note index, zero is a rest
    typedef logic [5:0] note_t;
    // Note length in beats
    typedef logic [5:0] dur_t;
    // Signed audio sample as the codec takes it
    typedef logic signed [15:0] sample_t;

    // Control FSM states
    typedef enum logic [1:0] {
        paused,
        playing,
        load_song
    } mcu_state_e;

    // Songs held in the ROM, indexed by a 2-bit song number
    localparam int NUM_SONGS = 4;

    // Square-wave peak of one voice
    localparam sample_t AMPLITUDE = 16'sd8192;

    // Phase steps of the top octave, A6 up to G#7
    // 20-bit phase accumulator stepped at 48 kHz
    localparam logic [19:0] TOP_STEP [12] = '{
        20'd38448, 20'd40734, 20'd43156, 20'd45722,
        20'd48441, 20'd51322, 20'd54373, 20'd57607,
        20'd61032, 20'd64661, 20'd68506, 20'd72580
    };

    // Note 1 is A1, every 12 notes up doubles the step
    function automatic logic [19:0] note_step(input note_t note);
        logic [5:0] idx;
        logic [2:0] octave;
        logic [3:0] semi;
        idx    = note - 6'd1;
        octave = 3'(idx / 12);
        semi   = 4'(idx % 12);
        // Rest has no pitch
        if (note == '0) begin
            return '0;
        end
        // Lower octaves are the top octave halved
        return TOP_STEP[semi] >> (3'd5 - octave);
    endfunction

endpackage

// File: hdl/music_player.sv
// Top level of the three-voice music player, wires control, song reader, voices and codec mixer
`timescale 1ns/1ps

module music_player
    import music_pkg::*;
#(
    parameter int BEAT_COUNT = 1000
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    play_button,
    input  logic    next_button,
    input  logic    new_frame,
    output logic    new_sample_generated,
    output sample_t sample_out
);

    // Control
    logic       play;
    logic       reset_player;
    logic [1:0] song;
    logic       song_done;

    // Sample timing
    logic       beat;
    logic       generate_next_sample;
    logic       note_sample_ready;

    // Voice outputs
    sample_t    sample_one;
    sample_t    sample_two;
    sample_t    sample_three;

    // One note channel per voice
    note_if voice1_if ();
    note_if voice2_if ();
    note_if voice3_if ();

    assign new_sample_generated = generate_next_sample;

    mcu u_mcu (
        .clk          (clk),
        .rst          (rst),
        .play_button  (play_button),
        .next_button  (next_button),
        .song_done    (song_done),
        .play         (play),
        .reset_player (reset_player),
        .song         (song)
    );

    // Beat from the 48 kHz sample request
    beat_generator #(
        .BEAT_COUNT (BEAT_COUNT)
    ) u_beat_generator (
        .clk  (clk),
        .rst  (rst),
        .en   (generate_next_sample),
        .beat (beat)
    );

    song_reader u_song_reader (
        .clk          (clk),
        .rst          (rst),
        .play         (play),
        .reset_player (reset_player),
        .song         (song),
        .song_done    (song_done),
        .voice1       (voice1_if),
        .voice2       (voice2_if),
        .voice3       (voice3_if)
    );

    // Voices run in lockstep, voice 1 supplies the ready strobe
    note_player u_note_player_1 (
        .clk                  (clk),
        .rst                  (rst),
        .play_enable          (play),
        .beat                 (beat),
        .generate_next_sample (generate_next_sample),
        .voice                (voice1_if),
        .sample_out           (sample_one),
        .new_sample_ready     (note_sample_ready)
    );

    note_player u_note_player_2 (
        .clk                  (clk),
        .rst                  (rst),
        .play_enable          (play),
        .beat                 (beat),
        .generate_next_sample (generate_next_sample),
        .voice                (voice2_if),
        .sample_out           (sample_two),
        .new_sample_ready     ()
    );

    note_player u_note_player_3 (
        .clk                  (clk),
        .rst                  (rst),
        .play_enable          (play),
        .beat                 (beat),
        .generate_next_sample (generate_next_sample),
        .voice                (voice3_if),
        .sample_out           (sample_three),
        .new_sample_ready     ()
    );

    codec_conditioner u_codec_conditioner (
        .clk                  (clk),
        .rst                  (rst),
        .sample_one           (sample_one),
        .sample_two           (sample_two),
        .sample_three         (sample_three),
        .latch_new_sample_in  (note_sample_ready),
        .new_frame            (new_frame),
        .generate_next_sample (generate_next_sample),
        .valid_sample         (sample_out)
    );

endmodule

// File: hdl/note_if.sv
// Note load and done handshake between the song reader and one note player
`timescale 1ns/1ps

interface note_if
    import music_pkg::*;
();

    // Note and length, valid while load is high
    note_t note;
    dur_t  duration;
    // One-cycle load strobe
    logic  load;
    // High while the player is idle
    logic  done;

    modport reader (
        output note,
        output duration,
        output load,
        input  done
    );

    modport player (
        input  note,
        input  duration,
        input  load,
        output done
    );

endinterface

// File: hdl/note_player.sv
// One voice, counts the note length in beats and makes a square wave from a phase accumulator
`timescale 1ns/1ps

module note_player
    import music_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    play_enable,
    input  logic    beat,
    input  logic    generate_next_sample,
    note_if.player  voice,
    output sample_t sample_out,
    output logic    new_sample_ready
);

    logic [19:0] step;
    dur_t        remaining;
    logic [19:0] phase;
    logic [19:0] phase_next;
    logic        sounding;

    // Idle once the length has run out
    assign voice.done = (remaining == '0);

    // A pitched note is held and playback runs
    assign sounding   = play_enable && !voice.done && (step != '0);
    assign phase_next = phase + step;

    // Remaining beats, frozen while paused
    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
        end else if (voice.load) begin
            remaining <= voice.duration;
        end else if (play_enable && beat && !voice.done) begin
            remaining <= remaining - 6'd1;
        end
    end

    // Pitch and phase
    // Each new note starts at phase 0
    always_ff @(posedge clk) begin
        if (voice.load) begin
            step  <= note_step(voice.note);
            phase <= '0;
        end else if (generate_next_sample && sounding) begin
            phase <= phase_next;
        end
    end

    // New sample one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_out       <= '0;
            new_sample_ready <= 1'b0;
        end else begin
            new_sample_ready <= generate_next_sample;
            if (generate_next_sample) begin
                // Sign taken from the top bit of the advanced phase
                if (sounding) begin
                    sample_out <= phase_next[19] ? -AMPLITUDE : AMPLITUDE;
                end else begin
                    sample_out <= '0;
                end
            end
        end
    end

    // Song reader only loads an idle voice
    a_load_when_done : assert property (@(posedge clk) disable iff (rst)
        voice.load |-> voice.done);

endmodule

// File: hdl/song_reader.sv
// Song ROM and row sequencer that loads all three voices whenever they are idle
`timescale 1ns/1ps

module song_reader
    import music_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       play,
    input  logic       reset_player,
    input  logic [1:0] song,
    output logic       song_done,
    note_if.reader     voice1,
    note_if.reader     voice2,
    note_if.reader     voice3
);

    // One ROM row, a note and a length per voice
    typedef struct packed {
        note_t n1;
        dur_t  d1;
        note_t n2;
        dur_t  d2;
        note_t n3;
        dur_t  d3;
    } row_t;

    logic [2:0] row;
    row_t       cur_row;
    logic       all_done;
    logic       end_row;
    logic       fire;

    // Song ROM, four songs of up to eight rows
    // Unlisted rows read as zero and end the song
    always_comb begin
        case ({song, row})
            // Song 0
            5'd0:  cur_row = {6'd49, 6'd2, 6'd53, 6'd2, 6'd56, 6'd2};
            5'd1:  cur_row = {6'd51, 6'd1, 6'd54, 6'd2, 6'd58, 6'd1};
            5'd2:  cur_row = {6'd0, 6'd1, 6'd53, 6'd1, 6'd56, 6'd1};
            // Song 1
            5'd8:  cur_row = {6'd37, 6'd3, 6'd41, 6'd3, 6'd44, 6'd3};
            5'd9:  cur_row = {6'd39, 6'd2, 6'd42, 6'd2, 6'd46, 6'd2};
            // Song 2
            5'd16: cur_row = {6'd44, 6'd2, 6'd48, 6'd2, 6'd51, 6'd2};
            5'd17: cur_row = {6'd46, 6'd1, 6'd49, 6'd1, 6'd53, 6'd1};
            // Song 3
            5'd24: cur_row = {6'd25, 6'd4, 6'd32, 6'd4, 6'd37, 6'd4};
            default: cur_row = '0;
        endcase
    end

    assign all_done = voice1.done && voice2.done && voice3.done;
    // All lengths zero marks the end of a song
    assign end_row  = (cur_row.d1 == '0) && (cur_row.d2 == '0) && (cur_row.d3 == '0);

    // Load every voice at once, only while playing
    assign fire      = play && all_done && !end_row;
    // Lasts one cycle, the FSM leaves playing right after
    assign song_done = play && all_done && end_row;

    // Row counter
    always_ff @(posedge clk) begin
        if (rst || reset_player) begin
            row <= '0;
        end else if (fire) begin
            row <= row + 3'd1;
        end
    end

    // Voice 1
    assign voice1.note     = cur_row.n1;
    assign voice1.duration = cur_row.d1;
    assign voice1.load     = fire;

    // Voice 2
    assign voice2.note     = cur_row.n2;
    assign voice2.duration = cur_row.d2;
    assign voice2.load     = fire;

    // Voice 3
    assign voice3.note     = cur_row.n3;
    assign voice3.duration = cur_row.d3;
    assign voice3.load     = fire;

endmodule

// File: tb.f
hdl/music_pkg.sv
hdl/note_if.sv
hdl/mcu.sv
hdl/beat_generator.sv
hdl/song_reader.sv
hdl/note_player.sv
hdl/codec_conditioner.sv
hdl/music_player.sv
test/tb_music_player.sv

// File: test/music_input.txt
// Columns: new_frame play_button next_button, expected new_sample_generated,
// expected sample_out (hex), test number, check flag. One row per clock cycle
// Test 1: reset state, first frame
0 0 0 0 0000 1 1
0 0 0 0 0000 1 1
1 0 0 0 0000 1 1
0 0 0 1 0000 1 1
// Test 2: play pressed, first mix still on its way
0 1 0 0 0000 2 1
1 0 0 0 0000 2 1
0 0 0 1 0000 2 1
0 0 0 0 0000 2 1
1 0 0 0 0000 2 1
// Test 3: song 0 rows 0 and 1, three voices
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
0 0 0 1 1800 3 1
0 0 0 0 1800 3 1
1 0 0 0 1800 3 1
// Test 4: pause with one voice left, silence, then resume
0 1 0 1 1800 4 1
0 0 0 0 1800 4 1
1 0 0 0 1800 4 1
0 0 0 1 0800 4 1
0 0 0 0 0800 4 1
1 0 0 0 0800 4 1
0 0 0 1 0000 4 1
0 0 0 0 0000 4 1
1 0 0 0 0000 4 1
0 0 0 1 0000 4 1
0 1 0 0 0000 4 1
1 0 0 0 0000 4 1
0 0 0 1 0000 4 1
0 0 0 0 0000 4 1
1 0 0 0 0000 4 1
0 0 0 1 0800 4 1
0 0 0 0 0800 4 1
1 0 0 0 0800 4 1
0 0 0 1 0800 4 1
0 0 0 0 0800 4 1
1 0 0 0 0800 4 1
0 0 0 1 0800 4 1
0 0 0 0 0800 4 1
1 0 0 0 0800 4 1
0 0 0 1 0800 4 1
0 0 0 0 0800 4 1
1 0 0 0 0800 4 1
// Test 5: last row with a rest, song end, song 1 paused
0 0 0 1 1000 5 1
0 0 0 0 1000 5 1
1 0 0 0 1000 5 1
0 0 0 1 1000 5 1
0 0 0 0 1000 5 1
1 0 0 0 1000 5 1
0 0 0 1 1000 5 1
0 0 0 0 1000 5 1
1 0 0 0 1000 5 1
0 0 0 1 1000 5 1
0 0 0 0 1000 5 1
1 0 0 0 1000 5 1
0 0 0 1 0000 5 1
// Test 6: play song 1 first row, next selects song 2 paused
0 1 0 0 0000 6 1
1 0 0 0 0000 6 1
0 0 0 1 0000 6 1
0 0 0 0 0000 6 1
1 0 0 0 0000 6 1
0 0 0 1 1800 6 1
0 0 0 0 1800 6 1
1 0 0 0 1800 6 1
0 0 1 1 1800 6 1
0 0 0 0 1800 6 1
1 0 0 0 1800 6 1
0 0 0 1 1800 6 1
0 0 0 0 1800 6 1
1 0 0 0 1800 6 1
0 0 0 1 0000 6 1
0 0 0 0 0000 6 1
1 0 0 0 0000 6 1

// File: test/tb_music_player.sv
// Testbench for the music player, replays the data-file table cycle by cycle and checks the outputs
`timescale 1ns/1ps

module tb_music_player
    import music_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 5;
    localparam int MARGIN_CYCLES = 100;
    // Inputs change this long after the rising edge
    localparam int DRIVE_DELAY   = 2;
    // Outputs sampled this long before the next edge
    localparam int SAMPLE_LEAD   = 2;

    // Columns of one stimulus row
    localparam int COLS       = 7;
    localparam int COL_FRAME  = 0;
    localparam int COL_PLAY   = 1;
    localparam int COL_NEXT   = 2;
    localparam int COL_GEN    = 3;
    localparam int COL_SAMPLE = 4;
    localparam int COL_TEST   = 5;
    localparam int COL_CHECK  = 6;
    localparam int MAX_STEPS  = 256;

    logic    clk;
    logic    rst;
    logic    play_button;
    logic    next_button;
    logic    new_frame;
    logic    new_sample_generated;
    sample_t sample_out;

    // Stimulus table, one row of COLS words per clock cycle
    logic [15:0] vectors [COLS*MAX_STEPS];
    int          num_steps;
    logic        loaded;
    int          step;

    // Per-test and overall counts
    int test_checks;
    int test_errors;
    int num_tests;
    int total_checks;
    int total_errors;

    // Short beats so whole songs fit in a few hundred cycles
    music_player #(
        .BEAT_COUNT (4)
    ) u_music_player (
        .clk                  (clk),
        .rst                  (rst),
        .play_button          (play_button),
        .next_button          (next_button),
        .new_frame            (new_frame),
        .new_sample_generated (new_sample_generated),
        .sample_out           (sample_out)
    );

    // Free-running clock
    always #(CLK_PERIOD / 2) clk = ~clk;

    // One word of the table
    function automatic logic [15:0] field(input int row, input int col);
        return vectors[COLS * row + col];
    endfunction

    // Unfilled rows stay unknown and mark the end of the table
    task automatic load_vectors();
        foreach (vectors[i]) begin
            vectors[i] = 'x;
        end
        $readmemh("test/music_input.txt", vectors);
        num_steps = 0;
        while (num_steps < MAX_STEPS && !$isunknown(field(num_steps, COL_TEST))) begin
            num_steps++;
        end
        loaded = 1'b1;
    endtask

    task automatic drive_step(input int row);
        new_frame   = field(row, COL_FRAME) != '0;
        play_button = field(row, COL_PLAY) != '0;
        next_button = field(row, COL_NEXT) != '0;
    endtask

    // Compares both outputs with the expected columns
    task automatic check_step(input int row);
        logic    exp_gen;
        sample_t exp_sample;
        exp_gen    = field(row, COL_GEN) != '0;
        exp_sample = field(row, COL_SAMPLE);
        test_checks++;
        assert (new_sample_generated === exp_gen) else begin
            $display("FAILED time %0t: step %0d new_sample_generated is %b, expected %b",
                     $time, row, new_sample_generated, exp_gen);
            test_errors++;
        end
        assert (sample_out === exp_sample) else begin
            $display("FAILED time %0t: step %0d sample_out is %0d, expected %0d",
                     $time, row, sample_out, exp_sample);
            test_errors++;
        end
    endtask

    task automatic finish_test(input int test_id);
        $display("test %0d done, %0d checks, %0d errors", test_id, test_checks, test_errors);
        num_tests++;
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        play_button  = 1'b0;
        next_button  = 1'b0;
        new_frame    = 1'b0;
        loaded       = 1'b0;
        test_checks  = 0;
        test_errors  = 0;
        num_tests    = 0;
        total_checks = 0;
        total_errors = 0;
        load_vectors();
        if (num_steps == 0) begin
            $display("no stimulus rows could be read from test/music_input.txt");
            total_errors++;
        end
        // Reset over the first edges, released together with the first row
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        for (step = 0; step < num_steps; step++) begin
            drive_step(step);
            #(CLK_PERIOD - DRIVE_DELAY - SAMPLE_LEAD);
            if (field(step, COL_CHECK) != '0) begin
                check_step(step);
            end
            // Last row of a test closes it
            if (step == num_steps - 1 ||
                field(step + 1, COL_TEST) != field(step, COL_TEST)) begin
                finish_test(field(step, COL_TEST));
            end
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        $display("%0d tests, %0d checks, %0d errors", num_tests, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog, table length plus reset and a margin
    initial begin
        wait (loaded);
        #((num_steps + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout, the stimulus table did not finish in time");
        $display("TB FAILED");
        $finish;
    end

endmodule
